// File: Makefile
VERILATOR  = verilator
FLAGS      = --timing
TOP        = lfsr_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/lfsr_tb.sv
// LFSR APB testbench with clock, APB tasks and shift register
// reference model, xorshift stimulus and assertion checks

`include "lfsr_defines.svh"

module lfsr_tb import lfsr_pkg::*;;

    localparam logic [31:0] RNG_SEED = 32'h311;
    localparam int          POLL_MAX = 40;     // STATUS polls before giving up

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    int          errors;
    int          timeouts;
    logic [31:0] rng;
    logic [31:0] model_state;

    lfsr_apb_top dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////
    // reference model

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // maximal-length feedback masks for the lengths used here
    function automatic logic [31:0] ref_mask(input int len, input logic four);
        if (!four) begin
            case (len)
                3:       return 32'h0000_0006;
                4:       return 32'h0000_000c;
                5:       return 32'h0000_0014;
                6:       return 32'h0000_0030;
                7:       return 32'h0000_0060;
                9:       return 32'h0000_0110;
                10:      return 32'h0000_0240;
                11:      return 32'h0000_0500;
                default: return 32'h0;
            endcase
        end
        case (len)
            5:       return 32'h0000_001e;
            6:       return 32'h0000_0036;
            7:       return 32'h0000_0078;
            8:       return 32'h0000_00b8;
            9:       return 32'h0000_01b0;
            12:      return 32'h0000_0ca0;
            16:      return 32'h0000_b400;
            20:      return 32'h000c_a000;
            default: return 32'h0;   // no entry
        endcase
    endfunction

    function automatic logic [31:0] ref_next(input logic [31:0] s, input logic [31:0] m);
        return {s[30:0], ^(s & m)};
    endfunction

    ////////////////////
    // checks and APB access

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic apb_xfer(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
        @(negedge clk);
        apb_req.psel    = 1'b1;   // setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;   // access phase
        #10;
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_eq("pready", 32'h1, {31'h0, apb_rsp.pready});
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata,
                             output logic slverr);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, wdata, unused, slverr);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata,
                            output logic slverr);
        apb_xfer(1'b0, addr, 32'h0, rdata, slverr);
    endtask

    task automatic write_ctrl(input int len, input logic four, input logic run);
        logic err;
        apb_write(`REG_CTRL, {23'h0, run, 2'b00, four, len[4:0]}, err);
        check_eq("pslverr ctrl write", 32'h0, {31'h0, err});
        model_state = 32'h1;   // reseed
    endtask

    // polls STATUS until a sample is buffered and returns head valid
    task automatic read_sample(output logic [31:0] value, output logic hvalid);
        logic [31:0] st;
        logic        err;
        int          n;
        n = 0;
        apb_read(`REG_STATUS, st, err);
        while (st[0] && n < POLL_MAX) begin
            apb_read(`REG_STATUS, st, err);
            n++;
        end
        assert (!st[0]) else begin
            timeouts++;
            $display("timeout at %0t: buffer stayed empty", $time);
        end
        assert (st[7:4] <= `FIFO_DEPTH) else begin
            errors++;
            $display("Error at %0t: count expected <= %0d, got %0d",
                     $time, `FIFO_DEPTH, st[7:4]);
        end
        hvalid = st[2];
        apb_read(`REG_DATA, value, err);
        check_eq("pslverr data read", 32'h0, {31'h0, err});
    endtask

    // reads n samples and compares them with the model
    task automatic check_run(input int len, input logic four, input int n);
        logic [31:0] mask;
        logic [31:0] value;
        logic        hvalid;
        mask = ref_mask(len, four);
        for (int i = 0; i < n; i++) begin
            read_sample(value, hvalid);
            model_state = ref_next(model_state, mask);
            check_eq("data", model_state, value);
            check_eq("head valid", 32'h1, {31'h0, hvalid});
        end
    endtask

    ////////////////////
    // stimulus

    initial begin
        logic [31:0] rd;
        logic [31:0] value;
        logic [31:0] first;
        logic        err;
        logic        hvalid;
        logic        dup;
        int          len;
        int          two_lens [8] = '{3, 4, 5, 6, 7, 9, 10, 11};
        int          four_lens[8] = '{5, 6, 7, 8, 9, 12, 16, 20};
        logic [4:0]  seen [$];

        errors      = 0;
        timeouts    = 0;
        rng         = RNG_SEED;
        model_state = 32'h1;
        apb_req     = '0;
        rst_n       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // reset state
        apb_read(`REG_CTRL, rd, err);
        check_eq("ctrl", 32'h0, rd);
        apb_read(`REG_STATUS, rd, err);
        check_eq("status", 32'h1, rd & 32'hf3);

        // 2-tap sequences
        for (int t = 0; t < 4; t++) begin
            rng = xorshift(rng);
            len = two_lens[rng[2:0]];
            write_ctrl(len, 1'b0, 1'b1);
            check_run(len, 1'b0, 4 + (xorshift(rng) % 8));
        end

        // period of the 5-bit sequence in its low bits
        write_ctrl(5, 1'b0, 1'b1);
        for (int i = 0; i < 32; i++) begin
            read_sample(value, hvalid);
            if (i == 0) begin
                first = value;
            end
            dup = 1'b0;
            for (int k = 0; k < seen.size(); k++) begin
                if (seen[k] == value[4:0]) begin
                    dup = 1'b1;
                end
            end
            assert (!dup || i == 31) else begin
                errors++;
                $display("Error at %0t: length 5 value %h repeated early", $time, value[4:0]);
            end
            seen.push_back(value[4:0]);
        end
        check_eq("length 5 wrap", {27'h0, first[4:0]}, {27'h0, value[4:0]});

        // 4-tap sequences
        write_ctrl(8, 1'b1, 1'b1);
        check_run(8, 1'b1, 6);
        write_ctrl(16, 1'b1, 1'b1);
        check_run(16, 1'b1, 6);
        for (int t = 0; t < 3; t++) begin
            rng = xorshift(rng);
            len = four_lens[rng[2:0]];
            write_ctrl(len, 1'b1, 1'b1);
            check_run(len, 1'b1, 4 + (xorshift(rng) % 8));
        end

        // invalid lengths give zero samples marked invalid
        write_ctrl(8, 1'b0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            read_sample(value, hvalid);
            check_eq("invalid data", 32'h0, value);
            check_eq("invalid head valid", 32'h0, {31'h0, hvalid});
        end
        write_ctrl(3, 1'b1, 1'b1);
        for (int i = 0; i < 4; i++) begin
            read_sample(value, hvalid);
            check_eq("invalid data", 32'h0, value);
            check_eq("invalid head valid", 32'h0, {31'h0, hvalid});
        end

        // back-pressure fill then idle then drain
        write_ctrl(16, 1'b1, 1'b1);
        len = 0;
        apb_read(`REG_STATUS, rd, err);
        while (!rd[1] && len < POLL_MAX) begin
            apb_read(`REG_STATUS, rd, err);
            len++;
        end
        assert (rd[1]) else begin
            timeouts++;
            $display("timeout at %0t: buffer never became full", $time);
        end
        repeat (8) @(negedge clk);
        check_run(16, 1'b1, 3 * `FIFO_DEPTH);

        // reseed in the middle of a sequence
        write_ctrl(7, 1'b0, 1'b1);
        check_run(7, 1'b0, 5);
        write_ctrl(7, 1'b0, 1'b1);
        check_run(7, 1'b0, 5);

        // APB errors
        write_ctrl(5, 1'b0, 1'b0);
        repeat (3) @(negedge clk);
        apb_read(`REG_DATA, rd, err);
        check_eq("pslverr empty data", 32'h1, {31'h0, err});
        apb_read(4'hc, rd, err);
        check_eq("pslverr unmapped", 32'h1, {31'h0, err});
        apb_write(`REG_STATUS, 32'h0, err);
        check_eq("pslverr status write", 32'h1, {31'h0, err});

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/apb_lfsr_regs.sv
// apb_lfsr_regs: APB slave with CTRL, STATUS and DATA registers
// pops samples from the buffer and issues flush and reseed

`include "lfsr_defines.svh"

module apb_lfsr_regs import lfsr_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  apb_req_t               apb_req,
    output apb_rsp_t               apb_rsp,
    output lfsr_cfg_t              cfg,
    output logic                   reseed,
    output logic                   flush,
    input  lfsr_sample_t           head,
    input  logic                   empty,
    input  logic                   full,
    input  logic [`FIFO_CNT_W-1:0] count,
    output logic                   pop
);

    logic                   access;
    logic                   rd;
    logic                   wr;
    logic                   sel_ctrl;
    logic                   sel_status;
    logic                   sel_data;
    logic                   err;
    logic                   ctrl_wr;
    logic                   ctrl_wr_q;   // one cycle after the CTRL access
    logic [`APB_DATA_W-1:0] ctrl_rdata;
    logic [`APB_DATA_W-1:0] status_rdata;
    logic [`APB_DATA_W-1:0] rdata;

    ////////////////////
    // decode

    assign access = apb_req.psel & apb_req.penable;
    assign rd     = access & ~apb_req.pwrite;
    assign wr     = access & apb_req.pwrite;

    assign sel_ctrl   = (apb_req.paddr == `REG_CTRL);
    assign sel_status = (apb_req.paddr == `REG_STATUS);
    assign sel_data   = (apb_req.paddr == `REG_DATA);

    // unmapped offset, write to a read-only register, or DATA with nothing buffered
    assign err = ~(sel_ctrl | sel_status | sel_data)
               | (apb_req.pwrite & (sel_status | sel_data))
               | (~apb_req.pwrite & sel_data & empty);

    assign ctrl_wr = wr & sel_ctrl;
    assign pop     = rd & sel_data & ~empty;  // taken at the end of the access

    ////////////////////
    // read data

    always_comb begin
        ctrl_rdata      = '0;
        ctrl_rdata[4:0] = cfg.length;
        ctrl_rdata[5]   = cfg.n_taps;
        ctrl_rdata[8]   = cfg.run;

        status_rdata      = '0;
        status_rdata[0]   = empty;
        status_rdata[1]   = full;
        status_rdata[2]   = head.valid;
        status_rdata[7:4] = 4'(count);
    end

    always_comb begin
        rdata = '0;
        if (rd) begin
            if (sel_ctrl) begin
                rdata = ctrl_rdata;
            end else if (sel_status) begin
                rdata = status_rdata;
            end else if (sel_data) begin
                rdata = head.value;
            end
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;          // zero wait states
    assign apb_rsp.pslverr = access & err;

    ////////////////////
    // CTRL register and restart pulse

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg       <= '0;
            ctrl_wr_q <= 1'b0;
        end else begin
            ctrl_wr_q <= ctrl_wr;
            if (ctrl_wr) begin
                cfg.length <= apb_req.pwdata[4:0];
                cfg.n_taps <= apb_req.pwdata[5];
                cfg.run    <= apb_req.pwdata[8];
            end
        end
    end

    // both land in the cycle after the write
    assign reseed = ctrl_wr_q;
    assign flush  = ctrl_wr_q;

endmodule

// File: rtl/lfsr_apb_top.sv
// lfsr_apb_top: LFSR producer, sample buffer and APB register block

`include "lfsr_defines.svh"

module lfsr_apb_top import lfsr_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    lfsr_cfg_t              cfg;
    logic                   reseed;
    logic                   flush;
    logic                   push;
    lfsr_sample_t           push_data;
    logic                   pop;
    lfsr_sample_t           head;
    logic                   empty;
    logic                   full;
    logic [`FIFO_CNT_W-1:0] count;

    lfsr_fibonacci lfsr_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .reseed    (reseed),
        .full      (full),
        .push      (push),
        .push_data (push_data)
    );

    sample_fifo #(
        .payload_t (lfsr_sample_t)
    ) fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full),
        .count     (count)
    );

    apb_lfsr_regs regs_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cfg     (cfg),
        .reseed  (reseed),
        .flush   (flush),
        .head    (head),
        .empty   (empty),
        .full    (full),
        .count   (count),
        .pop     (pop)
    );

endmodule

// File: rtl/lfsr_defines.svh
// widths, buffer depth and APB register offsets
// for the LFSR sample generator

`ifndef LFSR_DEFINES_SVH
`define LFSR_DEFINES_SVH

////////////////////
// datapath

`define LFSR_W      32  // shift register and sample value
`define LFSR_LEN_W  5   // length field, indexes the tap tables

////////////////////
// sample buffer

`define FIFO_DEPTH  4
`define FIFO_CNT_W  3   // holds 0..FIFO_DEPTH

////////////////////
// APB

`define APB_ADDR_W  4
`define APB_DATA_W  32

// byte offsets
`define REG_CTRL    4'h0
`define REG_STATUS  4'h4
`define REG_DATA    4'h8

`endif

// File: rtl/lfsr_fibonacci.sv
// lfsr_fibonacci: 32-bit Fibonacci shift register
// that pushes one sample per enabled cycle into the buffer

`include "lfsr_defines.svh"

module lfsr_fibonacci import lfsr_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  lfsr_cfg_t    cfg,
    input  logic         reseed,     // one-cycle pulse after a CTRL write
    input  logic         full,
    output logic         push,
    output lfsr_sample_t push_data
);

    localparam logic [`LFSR_W-1:0] SEED = 1;

    logic [`LFSR_W-1:0] state;
    logic [`LFSR_W-1:0] next_state;
    logic [`LFSR_W-1:0] mask;
    logic               mask_valid;
    logic               step;

    lfsr_tap_table tap_table_i (
        .length     (cfg.length),
        .n_taps     (cfg.n_taps),
        .mask       (mask),
        .mask_valid (mask_valid)
    );

    ////////////////////
    // feedback and step control

    // shift left, parity of tapped bits enters at bit 0
    assign next_state = {state[`LFSR_W-2:0], ^(state & mask)};

    // stall while the buffer has no room, skip the reseed cycle
    assign step = cfg.run & ~full & ~reseed;
    assign push = step;

    always_comb begin
        push_data.valid = mask_valid;
        push_data.value = mask_valid ? next_state : '0;  // invalid length gives 0
    end

    ////////////////////
    // state register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SEED;
        end else if (reseed) begin
            state <= SEED;
        end else if (step && mask_valid) begin
            state <= next_state;
        end
        // invalid length holds the state
    end

endmodule

// File: rtl/lfsr_pkg.sv
// lfsr_pkg: configuration, sample and APB struct types

`include "lfsr_defines.svh"

package lfsr_pkg;

    ////////////////////
    // generator

    // as seen by the producer, 7 bits
    typedef struct packed {
        logic                   run;     // enables generation
        logic                   n_taps;  // 1 selects the 4-tap table
        logic [`LFSR_LEN_W-1:0] length;
    } lfsr_cfg_t;

    // one buffered sample, 33 bits
    typedef struct packed {
        logic               valid;  // low for a length without a tap entry
        logic [`LFSR_W-1:0] value;
    } lfsr_sample_t;

    ////////////////////
    // APB

    // master to slave
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // slave to master
    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

// File: rtl/lfsr_tap_table.sv
// lfsr_tap_table: maximal-length Fibonacci feedback masks
// for 2 and 4 taps, indexed by register length

`include "lfsr_defines.svh"

module lfsr_tap_table (
    input  logic [`LFSR_LEN_W-1:0] length,
    input  logic                   n_taps,      // 1 selects the 4-tap table
    output logic [`LFSR_W-1:0]     mask,
    output logic                   mask_valid
);

    logic [`LFSR_W-1:0] mask_2;
    logic [`LFSR_W-1:0] mask_4;

    ////////////////////
    // 2-tap table, no entry for 0, 1, 8, 12-14, 16, 19, 24, 26, 27, 30

    always_comb begin
        case (length)
            5'd2:    mask_2 = 32'h0000_0003;
            5'd3:    mask_2 = 32'h0000_0006;
            5'd4:    mask_2 = 32'h0000_000c;
            5'd5:    mask_2 = 32'h0000_0014;
            5'd6:    mask_2 = 32'h0000_0030;
            5'd7:    mask_2 = 32'h0000_0060;
            5'd9:    mask_2 = 32'h0000_0110;
            5'd10:   mask_2 = 32'h0000_0240;
            5'd11:   mask_2 = 32'h0000_0500;
            5'd15:   mask_2 = 32'h0000_6000;
            5'd17:   mask_2 = 32'h0001_2000;
            5'd18:   mask_2 = 32'h0002_0400;
            5'd20:   mask_2 = 32'h0009_0000;
            5'd21:   mask_2 = 32'h0014_0000;
            5'd22:   mask_2 = 32'h0030_0000;
            5'd23:   mask_2 = 32'h0042_0000;
            5'd25:   mask_2 = 32'h0120_0000;
            5'd28:   mask_2 = 32'h0900_0000;
            5'd29:   mask_2 = 32'h1400_0000;
            5'd31:   mask_2 = 32'h4800_0000;
            default: mask_2 = '0;   // no entry
        endcase
    end

    ////////////////////
    // 4-tap table, lengths 5 and up

    always_comb begin
        case (length)
            5'd5:    mask_4 = 32'h0000_001e;
            5'd6:    mask_4 = 32'h0000_0036;
            5'd7:    mask_4 = 32'h0000_0078;
            5'd8:    mask_4 = 32'h0000_00b8;
            5'd9:    mask_4 = 32'h0000_01b0;
            5'd10:   mask_4 = 32'h0000_0360;
            5'd11:   mask_4 = 32'h0000_0740;
            5'd12:   mask_4 = 32'h0000_0ca0;
            5'd13:   mask_4 = 32'h0000_1b00;
            5'd14:   mask_4 = 32'h0000_3500;
            5'd15:   mask_4 = 32'h0000_7400;
            5'd16:   mask_4 = 32'h0000_b400;
            5'd17:   mask_4 = 32'h0001_e000;
            5'd18:   mask_4 = 32'h0003_9000;
            5'd19:   mask_4 = 32'h0007_2000;
            5'd20:   mask_4 = 32'h000c_a000;
            5'd21:   mask_4 = 32'h001c_8000;
            5'd22:   mask_4 = 32'h0027_0000;
            5'd23:   mask_4 = 32'h006a_0000;
            5'd24:   mask_4 = 32'h00d8_0000;
            5'd25:   mask_4 = 32'h01e0_0000;
            5'd26:   mask_4 = 32'h0388_0000;
            5'd27:   mask_4 = 32'h0720_0000;
            5'd28:   mask_4 = 32'h0ca0_0000;
            5'd29:   mask_4 = 32'h1d00_0000;
            5'd30:   mask_4 = 32'h3280_0000;
            5'd31:   mask_4 = 32'h7800_0000;
            default: mask_4 = '0;   // no entry
        endcase
    end

    // every real entry has its top tap set, so a zero mask means no entry
    assign mask       = n_taps ? mask_4 : mask_2;
    assign mask_valid = |mask;

endmodule

// File: rtl/sample_fifo.sv
// sample_fifo: circular buffer with a generic payload,
// flush, occupancy count and a combinational head

`include "lfsr_defines.svh"

module sample_fifo import lfsr_pkg::*; #(
    parameter type payload_t = lfsr_sample_t
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   push,
    input  payload_t               push_data,
    input  logic                   pop,
    output payload_t               head,
    output logic                   empty,
    output logic                   full,
    output logic [`FIFO_CNT_W-1:0] count
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam logic [PTR_W-1:0]       LAST_PTR  = PTR_W'(`FIFO_DEPTH - 1);
    localparam logic [`FIFO_CNT_W-1:0] DEPTH_CNT = `FIFO_DEPTH;

    payload_t         mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign empty = (count == '0);
    assign full  = (count == DEPTH_CNT);
    assign head  = mem[rd_ptr];

    assign do_pop  = pop & ~empty;
    assign do_push = push & (~full | do_pop);  // full buffer still takes push with pop

    ////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    ////////////////////
    // pointers and count, flush wins over push

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: vlog.f
+incdir+rtl
rtl/lfsr_pkg.sv
rtl/lfsr_tap_table.sv
rtl/lfsr_fibonacci.sv
rtl/sample_fifo.sv
rtl/apb_lfsr_regs.sv
rtl/lfsr_apb_top.sv
dv/lfsr_tb.sv
